// File: verilog/cic_cfg.svh
`ifndef CIC_CFG_SVH
`define CIC_CFG_SVH

// ==========================================================================
// datapath widths
// ==========================================================================
`define CIC_IN_W        18                      // input sample.
`define CIC_ACC_W       48                      // integrator and comb word.
`define CIC_OUT_W       18                      // gained output sample.
`define CIC_RATE_W      10                      // decimation factor field.

// ==========================================================================
// filter structure
// ==========================================================================
`define CIC_ORDER       3                       // integrators, and as many combs.
`define CIC_GAIN_DEPTH  4                       // strobes through combVarGain.

// outputs dropped after a load before the pipeline holds real data.
`define CIC_FLUSH_COUNT (`CIC_ORDER + `CIC_GAIN_DEPTH)

`endif

// File: verilog/cicPkg.sv
`include "cic_cfg.svh"

package cicPkg;

    // ======================================================================
    // configuration
    // ======================================================================
    // rate is the decimation factor, 2 to 1023.
    // the gain is (1 + mantissa/65536) * 2^exponent, relative to the top
    // 18 bits of the comb output.
    typedef struct packed {
        logic [`CIC_RATE_W-1:0] rate;
        logic [4:0]             exponent;
        logic [15:0]            mantissa;
    } cicCfgT;

    // ======================================================================
    // datapath words
    // ======================================================================
    typedef logic signed [`CIC_ACC_W-1:0] accT;        // wraps, combs undo it.
    typedef logic signed [`CIC_IN_W-1:0]  sampleT;     // input and output sample.

    // ======================================================================
    // control states
    // ======================================================================
    typedef enum logic [1:0] {
        stIdle  = 2'd0,                         // no configuration yet.
        stFlush = 2'd1,                         // waiting out stale outputs.
        stRun   = 2'd2                          // outputs are valid.
    } ctrlStateT;

endpackage

// File: verilog/cicIntegrator.sv
`timescale 1ns/1ns

module cicIntegrator import cicPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic clear,
    input  logic en,
    input  accT  x,
    output accT  y
);

    // ======================================================================
    // accumulator
    // ======================================================================
    // overflow is harmless here: the combs take differences modulo 2^48,
    // so the result is exact as long as the final output fits.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            y <= '0;
        end else if (clear) begin
            y <= '0;                            // restart with a new config.
        end else if (en) begin
            y <= y + x;                         // two's-complement wrap.
        end
    end

endmodule

// File: verilog/cicComb.sv
`timescale 1ns/1ns

module cicComb import cicPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic clear,
    input  logic en,
    input  accT  x,
    output accT  y
);

    accT delayX;                                // x at the previous strobe.

    // ======================================================================
    // differential delay of one decimated sample
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            delayX <= '0;
            y      <= '0;
        end else if (clear) begin
            delayX <= '0;
            y      <= '0;
        end else if (en) begin
            delayX <= x;
            y      <= x - delayX;               // wraps like the integrators.
        end
    end

endmodule

// File: verilog/decimCounter.sv
`timescale 1ns/1ns
`include "cic_cfg.svh"

module decimCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   clear,
    input  logic                   inEn,
    input  logic [`CIC_RATE_W-1:0] rate,
    output logic                   decimEn
);

    logic [`CIC_RATE_W-1:0] count;
    logic                   terminal;

    assign terminal = (count == rate - 1'b1);

    // strobe on every rate-th input. the pulse is held off in the clear
    // cycle so a strobe from the old rate never reaches the combs.
    assign decimEn = inEn && terminal && !clear;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inEn) begin
            if (terminal) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // a rate of 0 or 1 would never reach or always hit the terminal count.
    rateLegal: assert property (@(posedge clk) disable iff (!rstN)
        inEn |-> rate >= 2)
        else $error("decimation rate %0d is below 2.", rate);

endmodule

// File: verilog/mpy18x18PL1.sv
`timescale 1ns/1ns

module mpy18x18PL1 (
    input  logic               clk,
    input  logic               sclr,
    input  logic signed [17:0] a,
    input  logic signed [17:0] b,
    output logic signed [35:0] p
);

    // one register stage behind the multiplier array.
    always_ff @(posedge clk) begin
        if (sclr) begin
            p <= '0;
        end else begin
            p <= a * b;                         // full 36-bit signed product.
        end
    end

endmodule

// File: verilog/combVarGain.sv
`timescale 1ns/1ns
`include "cic_cfg.svh"

module combVarGain import cicPkg::*; (
    input  logic        clk,
    input  logic        clkEn,
    input  logic [4:0]  exponent,
    input  logic [15:0] mantissa,
    input  accT         din,
    output sampleT      dout
);

    localparam sampleT MaxPos = sampleT'((1 << (`CIC_OUT_W - 1)) - 1);
    localparam sampleT MaxNeg = -MaxPos;        // symmetric, never the min code.

    logic [4:0]         expSel;
    logic               sign;
    accT                upper;
    sampleT             dataBits;
    sampleT             shift;
    logic               satPos;
    logic               satNeg;
    logic [15:0]        man0;
    logic [15:0]        man1;
    logic signed [35:0] scaledValue;
    logic signed [35:0] product;

    // ======================================================================
    // strobes 1 and 2: shift select and saturate
    // ======================================================================
    always_comb begin
        expSel = (exponent == 5'd31) ? 5'd30 : exponent;   // 31 acts as 30.
        sign   = din[`CIC_ACC_W-1];
        // sign bit plus the bits shifted out above the selected field.
        upper  = din >>> (`CIC_ACC_W - 1 - expSel);
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            dataBits <= din[(`CIC_ACC_W - 1 - expSel) -: `CIC_OUT_W];
            satPos   <= !sign && (upper != '0);    // lost ones above a positive.
            satNeg   <= sign && (upper != '1);     // lost zeros above a negative.
            if (satPos) begin
                shift <= MaxPos;
            end else if (satNeg) begin
                shift <= MaxNeg;
            end else begin
                shift <= dataBits;
            end
        end
    end

    // mantissa follows the data so it lines up with shift.
    always_ff @(posedge clk) begin
        if (clkEn) begin
            man0 <= mantissa;
            man1 <= man0;
        end
    end

    // ======================================================================
    // strobe 3: multiply by 1 + mantissa/65536
    // ======================================================================
    mpy18x18PL1 gainScaler (
        .clk  (clk),
        .sclr (1'b0),
        .a    (shift),
        .b    ($signed({2'b01, man1})),
        .p    (scaledValue)
    );

    always_ff @(posedge clk) begin
        if (clkEn) begin
            product <= scaledValue;             // settled since the last strobe.
        end
    end

    // ======================================================================
    // strobe 4: output saturate
    // ======================================================================
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (product[35] && (product[34:33] != 2'b11)) begin
                dout <= MaxNeg;
            end else if (!product[35] && (product[34:33] != 2'b00)) begin
                dout <= MaxPos;
            end else begin
                dout <= product[33:16];
            end
        end
    end

    // both saturation points clip to +/-131071 through the pipeline.
    noMinCode: assert property (@(posedge clk)
        !$isunknown(dout) |-> dout != ~MaxPos)
        else $error("gain output reached the negative full-scale code.");

endmodule

// File: verilog/cicControl.sv
`timescale 1ns/1ns
`include "cic_cfg.svh"

module cicControl import cicPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   cfgLoad,
    input  logic   outStrobe,
    input  cicCfgT cfgIn,
    output cicCfgT cfgActive,
    output logic   clear,
    output logic   outEnable
);

    localparam int     FlushW     = $clog2(`CIC_FLUSH_COUNT + 1);
    localparam cicCfgT CfgDefault = '{rate: 2, exponent: '0, mantissa: '0};

    ctrlStateT         state;
    logic [FlushW-1:0] flushCnt;
    logic              countStrobe;

    // a strobe seen in the clear cycle belongs to the old configuration.
    assign countStrobe = outStrobe && !clear;
    assign outEnable   = (state == stRun);

    // ======================================================================
    // load, clear, flush, run
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stIdle;
            flushCnt  <= '0;
            clear     <= 1'b0;
            cfgActive <= CfgDefault;            // legal rate before any load.
        end else begin
            clear <= cfgLoad;                   // one cycle after the load.
            if (cfgLoad) begin
                cfgActive <= cfgIn;
                state     <= stFlush;           // restarts a flush in progress.
                flushCnt  <= '0;
            end else if (state == stFlush && countStrobe) begin
                flushCnt <= flushCnt + 1'b1;
                if (flushCnt == `CIC_FLUSH_COUNT - 1) begin
                    state <= stRun;
                end
            end
        end
    end

    // a loaded rate below 2 would stall or jam the decimation counter.
    loadLegal: assert property (@(posedge clk) disable iff (!rstN)
        cfgLoad |-> cfgIn.rate >= 2)
        else $error("configuration loaded with rate %0d.", cfgIn.rate);

endmodule

// File: verilog/cicDecimator.sv
`timescale 1ns/1ns
`include "cic_cfg.svh"

module cicDecimator import cicPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   inEn,
    input  logic   cfgLoad,
    input  sampleT din,
    input  cicCfgT cfg,
    output sampleT dout,
    output logic   doutValid
);

    cicCfgT cfgActive;
    logic   clear;
    logic   outEnable;
    logic   decimEn;
    logic   outStrobe;
    accT    intIn   [`CIC_ORDER];
    accT    intOut  [`CIC_ORDER];
    accT    combIn  [`CIC_ORDER];
    accT    combOut [`CIC_ORDER];

    cicControl u_cicControl (
        .clk       (clk),
        .rstN      (rstN),
        .cfgLoad   (cfgLoad),
        .outStrobe (outStrobe),
        .cfgIn     (cfg),
        .cfgActive (cfgActive),
        .clear     (clear),
        .outEnable (outEnable)
    );

    decimCounter u_decimCounter (
        .clk     (clk),
        .rstN    (rstN),
        .clear   (clear),
        .inEn    (inEn),
        .rate    (cfgActive.rate),
        .decimEn (decimEn)
    );

    // ======================================================================
    // integrators at the input rate, combs at the decimated rate
    // ======================================================================
    assign intIn[0]  = {{(`CIC_ACC_W - `CIC_IN_W){din[`CIC_IN_W-1]}}, din};
    assign combIn[0] = intOut[`CIC_ORDER-1];

    for (genvar k = 0; k < `CIC_ORDER; k++) begin : genInt
        if (k > 0) begin : genLink
            assign intIn[k] = intOut[k-1];
        end
        cicIntegrator u_cicIntegrator (
            .clk   (clk),
            .rstN  (rstN),
            .clear (clear),
            .en    (inEn),
            .x     (intIn[k]),
            .y     (intOut[k])
        );
    end

    for (genvar k = 0; k < `CIC_ORDER; k++) begin : genComb
        if (k > 0) begin : genLink
            assign combIn[k] = combOut[k-1];
        end
        cicComb u_cicComb (
            .clk   (clk),
            .rstN  (rstN),
            .clear (clear),
            .en    (decimEn),
            .x     (combIn[k]),
            .y     (combOut[k])
        );
    end

    combVarGain u_combVarGain (
        .clk      (clk),
        .clkEn    (decimEn),
        .exponent (cfgActive.exponent),
        .mantissa (cfgActive.mantissa),
        .din      (combOut[`CIC_ORDER-1]),
        .dout     (dout)
    );

    // ======================================================================
    // output strobe
    // ======================================================================
    // dout changes on the decimEn edge, so the strobe trails it by a cycle.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= decimEn;
        end
    end

    assign doutValid = outStrobe && outEnable;  // quiet until run.

endmodule

// File: testbench/tbCicChecks.svh
`ifndef TB_CIC_CHECKS_SVH
`define TB_CIC_CHECKS_SVH

localparam int MaxOut = (1 << (`CIC_OUT_W - 1)) - 1;

// ==========================================================================
// filter model
// ==========================================================================
// last integrator value seen by the first comb at a strobe, after
// strobe * rate - 1 samples of dc: dc * C(n, 3).
function automatic longint integratorSum(input longint dc, input int rate, input int strobe);
    longint n;
    if (strobe < 1) begin
        return 0;
    end
    n = longint'(strobe) * rate - 1;
    return dc * (n * (n - 1) * (n - 2) / 6);
endfunction

// third comb output after a strobe. the first outputs of a flush still
// carry the step response; from strobe 6 on it is the dc gain rate^3.
function automatic accT combModel(input longint dc, input int rate, input int strobe);
    longint d;
    if (strobe >= 6) begin
        d = dc * rate * rate * rate;
    end else begin
        d = integratorSum(dc, rate, strobe - 2) - 3 * integratorSum(dc, rate, strobe - 3)
          + 3 * integratorSum(dc, rate, strobe - 4) - integratorSum(dc, rate, strobe - 5);
    end
    return accT'(d);                            // combs work modulo 2^48.
endfunction

function automatic sampleT gainModel(input accT x, input logic [4:0] exponent,
                                     input logic [15:0] mantissa);
    int     e;
    longint v;
    longint p;
    longint limit;
    e     = (exponent == 5'd31) ? 30 : int'(exponent);
    limit = longint'(1) << 33;
    v     = longint'(x) >>> (30 - e);           // 18-bit window below the sign.
    if (v > MaxOut) begin
        v = MaxOut;
    end else if (v < -MaxOut - 1) begin
        v = -MaxOut;
    end
    p = v * (longint'(mantissa) + 65536);
    if (p >= limit) begin
        return sampleT'(MaxOut);
    end else if (p < -limit) begin
        return sampleT'(-MaxOut);
    end
    return sampleT'(p >>> 16);
endfunction

// ==========================================================================
// compare tasks
// ==========================================================================
task automatic checkSample(input string name, input sampleT actual, input sampleT expected);
    if (actual !== expected) begin
        stopRun($sformatf("Fail at %0t ns: %s is %0d, expected %0d.",
                          $time, name, actual, expected));
    end
endtask

task automatic checkState(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        stopRun($sformatf("Fail at %0t ns: %s is %0b, expected %0b.",
                          $time, name, actual, expected));
    end
endtask

// ==========================================================================
// random source
// ==========================================================================
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;     // taps 32, 22, 2, 1.
    end
    return state >> 1;
endfunction

task automatic drawBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        value     = {value[30:0], lfsrState[0]};
        lfsrState = lfsrStep(lfsrState);
    end
endtask

`endif

// File: testbench/tbCicDecimator.sv
`timescale 1ns/1ns
`include "cic_cfg.svh"

module tbCicDecimator import cicPkg::*; ();

    typedef struct packed {
        cicCfgT     cfg;
        sampleT     dc;                         // constant input level.
        logic [1:0] spacing;                    // cycles between input strobes.
        logic [7:0] nCheck;                     // 0 reloads again in mid flush.
        logic       drawRandom;                 // dc, exponent, mantissa from the LFSR.
    } stimRowT;

    localparam int NumRows    = 13;
    localparam int IdleCycles = 60;

    logic        clk;
    logic        rstN;
    logic        inEn;
    logic        cfgLoad;
    sampleT      din;
    cicCfgT      cfg;
    sampleT      dout;
    logic        doutValid;
    stimRowT     stimTable [NumRows];
    stimRowT     activeRow;
    int          inCount      = 0;
    int          dropCnt      = 0;
    int          phase        = 0;
    int          outsChecked  = 0;
    logic        pendingCount = 1'b0;
    logic        loaded       = 1'b0;
    logic [31:0] lfsrState    = 32'd71235;

    cicDecimator u_cicDecimator (
        .clk       (clk),
        .rstN      (rstN),
        .inEn      (inEn),
        .cfgLoad   (cfgLoad),
        .din       (din),
        .cfg       (cfg),
        .dout      (dout),
        .doutValid (doutValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t ns.", $time);
    endtask

    `include "tbCicChecks.svh"

    // ======================================================================
    // stimulus table
    // ======================================================================
    function automatic stimRowT makeRow(input int rate, input int exponent, input int mantissa,
                                        input int dc, input int spacing, input int nCheck,
                                        input bit drawRandom);
        stimRowT row;
        row.cfg.rate     = rate[`CIC_RATE_W-1:0];
        row.cfg.exponent = exponent[4:0];
        row.cfg.mantissa = mantissa[15:0];
        row.dc           = dc[`CIC_IN_W-1:0];
        row.spacing      = spacing[1:0];
        row.nCheck       = nCheck[7:0];
        row.drawRandom   = drawRandom;
        return row;
    endfunction

    task automatic loadTable();
        stimTable[0]  = makeRow(4, 30, 0, 100, 1, 6, 1'b0);
        stimTable[1]  = makeRow(8, 30, 0, -37, 3, 5, 1'b0);
        stimTable[2]  = makeRow(5, 28, 16384, 250, 1, 5, 1'b0);
        stimTable[3]  = makeRow(16, 24, 40000, -900, 1, 4, 1'b0);
        stimTable[4]  = makeRow(6, 29, 65535, 1200, 3, 4, 1'b0);   // product clips.
        stimTable[5]  = makeRow(8, 30, 0, 100000, 1, 4, 1'b0);
        stimTable[6]  = makeRow(8, 30, 12345, -100000, 1, 4, 1'b0);
        stimTable[7]  = makeRow(12, 26, 0, 500, 1, 0, 1'b0);       // cut off in flush.
        stimTable[8]  = makeRow(3, 30, 8192, -2000, 1, 6, 1'b0);
        stimTable[9]  = makeRow(4, 0, 0, 0, 1, 4, 1'b1);
        stimTable[10] = makeRow(4, 0, 0, 0, 3, 4, 1'b1);
        stimTable[11] = makeRow(4, 0, 0, 0, 1, 4, 1'b1);
        stimTable[12] = makeRow(4, 0, 0, 0, 3, 4, 1'b1);
    endtask

    // one clock: check the last rising edge, then drive the next one.
    task automatic stepCycle(input logic loadNow, input stimRowT nextRow);
        int   rate;
        int   strobe;
        logic expValid;
        @(negedge clk);
        rate = int'(activeRow.cfg.rate);
        if (pendingCount) begin
            inCount++;
        end
        strobe   = inCount / rate;
        expValid = pendingCount && (inCount % rate == 0) && (strobe > `CIC_FLUSH_COUNT);
        checkState("doutValid", doutValid, expValid);
        if (expValid) begin
            checkSample("dout", dout,
                gainModel(combModel(longint'(activeRow.dc), rate, strobe - `CIC_GAIN_DEPTH),
                          activeRow.cfg.exponent, activeRow.cfg.mantissa));
            outsChecked++;
        end
        cfgLoad = loadNow;
        if (loadNow) begin
            activeRow   = nextRow;
            cfg         = nextRow.cfg;
            din         = nextRow.dc;
            dropCnt     = 2;                    // load and clear cycles lose their input.
            inCount     = 0;
            phase       = 0;
            outsChecked = 0;
            loaded      = 1'b1;
        end
        inEn         = (phase == 0);
        phase        = (phase + 1) % int'(activeRow.spacing);
        pendingCount = inEn && loaded && (dropCnt == 0);
        if (dropCnt > 0) begin
            dropCnt--;
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        longint      limitNs;
        int          periods;
        stimRowT     row;
        logic [31:0] bits;
        rstN      = 1'b0;
        inEn      = 1'b0;
        cfgLoad   = 1'b0;
        din       = 18'sd1234;
        cfg       = '0;
        activeRow = makeRow(2, 0, 0, 0, 1, 0, 1'b0);
        loadTable();

        limitNs = 2000 + IdleCycles * 8;
        for (int r = 0; r < NumRows; r++) begin
            periods = `CIC_FLUSH_COUNT + 1
                    + ((stimTable[r].nCheck == 0) ? 3 : stimTable[r].nCheck);
            limitNs += 2 * 8 * periods * stimTable[r].cfg.rate * stimTable[r].spacing;
        end
        fork
            begin
                #(limitNs);
                stopRun($sformatf("timeout: dout pulses still missing after %0d ns.", limitNs));
            end
        join_none

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (IdleCycles) stepCycle(1'b0, activeRow);     // no load yet, no output.

        for (int r = 0; r < NumRows; r++) begin
            row = stimTable[r];
            if (row.drawRandom) begin
                drawBits(5, bits);
                row.cfg.exponent = bits[4:0];
                drawBits(16, bits);
                row.cfg.mantissa = bits[15:0];
                drawBits(`CIC_IN_W, bits);
                row.dc = bits[`CIC_IN_W-1:0];
            end
            stepCycle(1'b1, row);
            if (row.nCheck == 0) begin
                while (inCount < 3 * int'(row.cfg.rate)) stepCycle(1'b0, row);
            end else begin
                while (outsChecked < int'(row.nCheck)) stepCycle(1'b0, row);
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verilog
+incdir+testbench
verilog/cicPkg.sv
verilog/cicIntegrator.sv
verilog/cicComb.sv
verilog/decimCounter.sv
verilog/mpy18x18PL1.sv
verilog/combVarGain.sv
verilog/cicControl.sv
verilog/cicDecimator.sv
testbench/tbCicDecimator.sv
